//--- frame_buffer_cfg.svh
`ifndef FRAME_BUFFER_CFG_SVH
`define FRAME_BUFFER_CFG_SVH

// Buffer depth is 2**FB_ADDR_WIDTH words.
// One slot always stays free to tell full from empty.
`define FB_ADDR_WIDTH 6

// Payload width of one stream word.
`define FB_DATA_WIDTH 16

`endif

//--- mem_pkg.sv
`include "frame_buffer_cfg.svh"

package mem_pkg;

   // Address into the frame SRAM, also used for all pointers.
   typedef logic [`FB_ADDR_WIDTH-1:0] sram_addr_t;

   // Pointer step, wraps at the end of the array.
   function automatic sram_addr_t ptr_next(input sram_addr_t ptr);
      return ptr + sram_addr_t'(1);
   endfunction

endpackage

//--- stream_pkg.sv
`include "frame_buffer_cfg.svh"

package stream_pkg;

   // One data word of the input and output streams.
   typedef logic [`FB_DATA_WIDTH-1:0] sample_t;

   // Word as it sits in the SRAM.
   // The last flag travels with the data so frame
   // boundaries survive the buffer.
   typedef struct packed
   {
      logic    last;   // Final word of a frame.
      sample_t data;
   } buffer_word_t;

endpackage

//--- sram_if.sv
`timescale 1ns/1ns

interface sram_if;
   import mem_pkg::*;
   import stream_pkg::*;

   // Write port, owned by the producer.
   logic         wr_select;
   sram_addr_t   wr_address;
   buffer_word_t wr_word;

   // Read port, owned by the consumer.
   logic         rd_select;
   sram_addr_t   rd_address;
   buffer_word_t rd_word;      // Registered in the SRAM.

   modport writer
   (
      output wr_select,
      output wr_address,
      output wr_word
   );

   modport reader
   (
      output rd_select,
      output rd_address,
      input  rd_word
   );

   modport memory
   (
      input  wr_select,
      input  wr_address,
      input  wr_word,
      input  rd_select,
      input  rd_address,
      output rd_word
   );

endinterface

//--- sram_dual_port.sv
`timescale 1ns/1ns
`include "frame_buffer_cfg.svh"

module sram_dual_port
#(
   parameter int address_width = `FB_ADDR_WIDTH
)
(
   input logic    sram_clock,
   sram_if.memory mem
);
   import stream_pkg::*;

   localparam int depth = 1 << address_width;

   buffer_word_t ram [depth];

   logic [address_width-1:0] wr_index;
   logic [address_width-1:0] rd_index;

   // Bus addresses resized to the array.
   assign wr_index = address_width'(mem.wr_address);
   assign rd_index = address_width'(mem.rd_address);

   // Write port.
   always_ff @(posedge sram_clock)
   begin
      if (mem.wr_select)
      begin
         ram[wr_index] <= mem.wr_word;
      end
   end

   // Read port, data valid the cycle after select.
   always_ff @(posedge sram_clock)
   begin
      if (mem.rd_select)
      begin
         mem.rd_word <= ram[rd_index]; // Holds between reads.
      end
   end

endmodule

//--- frame_writer.sv
`timescale 1ns/1ns

module frame_writer
(
   input  logic                 sram_clock,
   input  logic                 rst,
   input  logic                 in_valid,
   input  logic                 in_last,
   input  stream_pkg::sample_t  in_data,
   input  mem_pkg::sram_addr_t  read_ptr,
   output mem_pkg::sram_addr_t  commit_ptr,
   output logic                 frame_dropped,
   sram_if.writer               mem
);
   import mem_pkg::*;
   import stream_pkg::*;

   sram_addr_t   wr_ptr;     // Next free slot of the open frame.
   sram_addr_t   next_ptr;
   logic         discarding; // Skipping the rest of a dropped frame.
   logic         full;
   logic         accept;
   buffer_word_t in_word;

   assign next_ptr = ptr_next(wr_ptr);

   // Open frame words count as used, so compare against wr_ptr.
   assign full = (next_ptr == read_ptr);

   assign accept = in_valid && !discarding && !full;

   assign in_word.last = in_last;
   assign in_word.data = in_data;

   // Word lands in the SRAM at the edge that accepts it.
   assign mem.wr_select  = accept;
   assign mem.wr_address = wr_ptr;
   assign mem.wr_word    = in_word;

   always_ff @(posedge sram_clock)
   begin
      if (rst)
      begin
         wr_ptr        <= '0;
         commit_ptr    <= '0;
         discarding    <= 1'b0;
         frame_dropped <= 1'b0;
      end
      else
      begin
         frame_dropped <= 1'b0;
         if (in_valid)
         begin
            if (discarding)
            begin
               if (in_last)
               begin
                  discarding <= 1'b0; // Next word starts a fresh frame.
               end
            end
            else if (full)
            begin
               // No room. Throw away what was written of this frame.
               wr_ptr        <= commit_ptr;
               frame_dropped <= 1'b1;
               discarding    <= !in_last;
            end
            else
            begin
               wr_ptr <= next_ptr;
               if (in_last)
               begin
                  commit_ptr <= next_ptr; // Frame now visible to the reader.
               end
            end
         end
      end
   end

endmodule

//--- frame_reader.sv
`timescale 1ns/1ns

module frame_reader
(
   input  logic                 sram_clock,
   input  logic                 rst,
   input  logic                 hold,
   input  mem_pkg::sram_addr_t  commit_ptr,
   output mem_pkg::sram_addr_t  read_ptr,
   output logic                 out_valid,
   output logic                 out_last,
   output stream_pkg::sample_t  out_data,
   sram_if.reader               mem
);
   import mem_pkg::*;

   logic fetch;
   logic pending;

   // Committed words are waiting.
   assign pending = (read_ptr != commit_ptr);

   assign fetch = pending && !hold;

   // One fetch per cycle, no wait on the previous read.
   assign mem.rd_select  = fetch;
   assign mem.rd_address = read_ptr;

   always_ff @(posedge sram_clock)
   begin
      if (rst)
      begin
         read_ptr  <= '0;
         out_valid <= 1'b0;
      end
      else
      begin
         out_valid <= fetch; // Same edge the SRAM loads rd_word.
         if (fetch)
         begin
            read_ptr <= ptr_next(read_ptr);
         end
      end
   end

   // Stored record split back into stream fields.
   assign out_data = mem.rd_word.data;
   assign out_last = mem.rd_word.last;

endmodule

//--- frame_buffer_top.sv
`timescale 1ns/1ns
`include "frame_buffer_cfg.svh"

module frame_buffer_top
(
   input  logic                 sram_clock,
   input  logic                 rst,
   input  logic                 in_valid,
   input  logic                 in_last,
   input  logic                 hold,
   input  stream_pkg::sample_t  in_data,
   output logic                 out_valid,
   output logic                 out_last,
   output logic                 frame_dropped,
   output stream_pkg::sample_t  out_data
);
   import mem_pkg::*;

   sram_addr_t commit_ptr; // End of the newest complete frame.
   sram_addr_t read_ptr;

   sram_if mem_bus();

   frame_writer frame_writer_i
   (
      .sram_clock    (sram_clock),
      .rst           (rst),
      .in_valid      (in_valid),
      .in_last       (in_last),
      .in_data       (in_data),
      .read_ptr      (read_ptr),
      .commit_ptr    (commit_ptr),
      .frame_dropped (frame_dropped),
      .mem           (mem_bus.writer)
   );

   sram_dual_port
   #(
      .address_width (`FB_ADDR_WIDTH)
   )
   sram_dual_port_i
   (
      .sram_clock (sram_clock),
      .mem        (mem_bus.memory)
   );

   frame_reader frame_reader_i
   (
      .sram_clock (sram_clock),
      .rst        (rst),
      .hold       (hold),
      .commit_ptr (commit_ptr),
      .read_ptr   (read_ptr),
      .out_valid  (out_valid),
      .out_last   (out_last),
      .out_data   (out_data),
      .mem        (mem_bus.reader)
   );

endmodule

//--- tb_frame_buffer.sv
`timescale 1ns/1ns
`include "frame_buffer_cfg.svh"

module tb_frame_buffer;
   import stream_pkg::*;

   localparam int capacity = (1 << `FB_ADDR_WIDTH) - 1;

   logic    sram_clock;
   logic    rst;
   logic    in_valid;
   logic    in_last;
   logic    hold;
   sample_t in_data;
   logic    out_valid;
   logic    out_last;
   logic    frame_dropped;
   sample_t out_data;

   buffer_word_t exp_q [$];   // Words of accepted frames, in output order.
   buffer_word_t exp_head;
   logic         exp_ready;
   logic         committed_any;
   logic         drop_due;      // Word on the bus overflows the model.
   logic         latency_probe; // Last word of a frame sent to an empty buffer.
   logic         no_hold_phase;
   integer       seed;
   int           occ;           // Words held, open frame included.
   int           errors;
   int           timeouts;
   int           words_out;
   int           drops_seen;
   int           drops_expected;

   frame_buffer_top frame_buffer_top_i
   (
      .sram_clock    (sram_clock),
      .rst           (rst),
      .in_valid      (in_valid),
      .in_last       (in_last),
      .hold          (hold),
      .in_data       (in_data),
      .out_valid     (out_valid),
      .out_last      (out_last),
      .frame_dropped (frame_dropped),
      .out_data      (out_data)
   );

   initial
   begin
      sram_clock = 1'b0;
      forever #4 sram_clock = ~sram_clock;
   end

   // Model side of the output, front word ready for the next edge.
   always @(posedge sram_clock)
   begin
      if (!rst && out_valid)
      begin
         words_out = words_out + 1;
         if (exp_q.size() > 0)
         begin
            void'(exp_q.pop_front());
            occ = occ - 1;
         end
      end
      if (!rst && frame_dropped)
      begin
         drops_seen = drops_seen + 1;
      end
      exp_ready <= (exp_q.size() > 0);
      exp_head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
   end

   check_word: assert property (@(posedge sram_clock) disable iff (rst)
      out_valid |-> (exp_ready && out_data == exp_head.data && out_last == exp_head.last))
   else
   begin
      errors = errors + 1;
      $display("error at %0t: got %h last %b, expected %h last %b (model ready %b)",
               $time, out_data, out_last, exp_head.data, exp_head.last, exp_ready);
   end

   check_quiet_start: assert property (@(posedge sram_clock) disable iff (rst)
      !committed_any |-> (!out_valid && !frame_dropped))
   else
   begin
      errors = errors + 1;
      $display("error at %0t: output active before the first commit", $time);
   end

   check_hold: assert property (@(posedge sram_clock) disable iff (rst)
      $past(hold) |-> !out_valid)
   else
   begin
      errors = errors + 1;
      $display("error at %0t: out_valid high while hold was set", $time);
   end

   check_latency: assert property (@(posedge sram_clock) disable iff (rst)
      ($past(latency_probe, 2) |-> out_valid) and ($past(latency_probe) |-> !out_valid))
   else
   begin
      errors = errors + 1;
      $display("error at %0t: first word not one cycle after the last input", $time);
   end

   // Without hold a frame leaves in one unbroken burst.
   check_burst: assert property (@(posedge sram_clock) disable iff (rst)
      (no_hold_phase && $past(out_valid) && !$past(out_last)) |-> out_valid)
   else
   begin
      errors = errors + 1;
      $display("error at %0t: gap inside an output frame", $time);
   end

   check_drop: assert property (@(posedge sram_clock) disable iff (rst)
      frame_dropped == $past(drop_due))
   else
   begin
      errors = errors + 1;
      $display("error at %0t: frame_dropped %b disagrees with the predicted drop",
               $time, frame_dropped);
   end

   function automatic int rand_range(input int lo, input int hi);
      int span;
      span = hi - lo + 1;
      return lo + int'($unsigned($random(seed)) % span);
   endfunction

   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(posedge sram_clock);
         in_valid      <= 1'b0;
         in_last       <= 1'b0;
         drop_due      <= 1'b0;
         latency_probe <= 1'b0;
      end
   endtask

   // Sends one frame and applies the full rule to every word.
   task automatic send_frame(input int len, input int max_gap, input bit probe);
      buffer_word_t pending [$];
      buffer_word_t word;
      bit           dropping;
      bit           drop_now;
      int           i;
      dropping = 1'b0;
      for (i = 0; i < len; i++)
      begin
         idle_cycles(rand_range(0, max_gap));
         @(posedge sram_clock);
         word.data = sample_t'($random(seed));
         word.last = (i == len - 1);
         drop_now  = 1'b0;
         if (!dropping && occ == capacity)
         begin
            drop_now = 1'b1; // Open words get rewound.
            dropping = 1'b1;
            occ = occ - pending.size();
            pending.delete();
            drops_expected = drops_expected + 1;
         end
         else if (!dropping)
         begin
            occ = occ + 1;
            pending.push_back(word);
         end
         in_valid      <= 1'b1;
         in_data       <= word.data;
         in_last       <= word.last;
         drop_due      <= drop_now;
         latency_probe <= probe && word.last;
      end
      if (!dropping)
      begin
         foreach (pending[k])
         begin
            exp_q.push_back(pending[k]);
         end
         committed_any <= 1'b1;
      end
      idle_cycles(1);
   endtask

   task automatic wait_drain(input int limit);
      int cycles;
      cycles = 0;
      while (exp_q.size() > 0 && cycles < limit)
      begin
         @(posedge sram_clock);
         cycles = cycles + 1;
      end
      if (exp_q.size() > 0)
      begin
         timeouts = timeouts + 1;
         $display("timeout: %0d words never came out of the buffer", exp_q.size());
      end
      idle_cycles(3);
   endtask

   initial
   begin
      seed = 42;
      occ = 0;
      errors = 0;
      timeouts = 0;
      words_out = 0;
      drops_seen = 0;
      drops_expected = 0;
      rst           <= 1'b1;
      in_valid      <= 1'b0;
      in_last       <= 1'b0;
      in_data       <= '0;
      hold          <= 1'b0;
      committed_any <= 1'b0;
      drop_due      <= 1'b0;
      latency_probe <= 1'b0;
      no_hold_phase <= 1'b0;
      repeat (5) @(posedge sram_clock);
      rst <= 1'b0;
      idle_cycles(6);

      no_hold_phase <= 1'b1;
      send_frame(5, 0, 1'b1);
      wait_drain(100);
      repeat (20)
      begin
         send_frame(rand_range(1, 8), 2, 1'b0);
      end
      wait_drain(200);

      no_hold_phase <= 1'b0;
      hold          <= 1'b1;
      repeat (4)
      begin
         send_frame(rand_range(1, 8), 2, 1'b0);
      end
      idle_cycles(8);
      hold <= 1'b0;
      wait_drain(200);

      // Fill with the reader paused until one frame overflows.
      hold <= 1'b1;
      repeat (40)
      begin
         if (drops_expected == 0)
         begin
            send_frame(rand_range(4, 12), 1, 1'b0);
         end
      end
      idle_cycles(4);
      hold <= 1'b0;
      wait_drain(400);
      assert (drops_seen == 1 && drops_expected == 1)
      else
      begin
         errors = errors + 1;
         $display("error at %0t: %0d drop strobes seen, %0d predicted, expected one",
                  $time, drops_seen, drops_expected);
      end

      no_hold_phase <= 1'b1;
      send_frame(7, 0, 1'b1);
      wait_drain(100);

      $display("errors: %0d, timeouts: %0d, words out: %0d, drops: %0d",
               errors, timeouts, words_out, drops_seen);
      if (errors == 0 && timeouts == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

//--- project.f
+incdir+.
mem_pkg.sv
stream_pkg.sv
sram_if.sv
sram_dual_port.sv
frame_writer.sv
frame_reader.sv
frame_buffer_top.sv
tb_frame_buffer.sv

//--- run_sim.sh
#!/bin/sh
# Builds the frame buffer testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
   -f project.f --top-module tb_frame_buffer -o tb_frame_buffer
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

output=$(./obj_dir/tb_frame_buffer)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
   exit 0
fi
echo "pass line not found in the output"
exit 1
